//--- st7735_ctrl.f
lcd_cmd_pkg.sv
lcd_ctrl_pkg.sv
spi_word_if.sv
spi_shifter.sv
delay_timer.sv
init_rom.sv
lcd_sequencer.sv
st7735_ctrl.sv
tb_clock_gen.sv
st7735_ctrl_props.sv
st7735_ctrl_tb.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := st7735_ctrl_tb
FLIST := st7735_ctrl.f
OBJ   := obj_dir
LOG   := sim.log
FAIL  := Simulation finished: FAIL
PASS  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: compile
	-./$(OBJ)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL)" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- st7735_ctrl_tb.sv
`timescale 1ns/1ps

module st7735_ctrl_tb;

    localparam int DELAY_CYCLES = 20;
    localparam int WIDTH        = 4;
    localparam int HEIGHT       = 3;
    localparam int TABLE_LEN    = 40;
    localparam int FRAME_WORDS  = 11 + WIDTH * HEIGHT;
    // 16 bits at two cycles each, plus start and gap
    localparam int WORD_CYCLES  = 2 * 16 + 4;
    localparam int RUN_CYCLES   = 8 + 3 * DELAY_CYCLES
                                + (1 + TABLE_LEN + 2 * FRAME_WORDS) * WORD_CYCLES;
    localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES;

    // configuration table in send order, entry 0 in the top byte
    localparam logic [8*TABLE_LEN-1:0] TABLE_BYTES = {
        8'hB1, 8'h01, 8'h2C, 8'h2D, 8'hB2, 8'h01, 8'h2C, 8'h2D,
        8'hB3, 8'h01, 8'h2C, 8'h2D, 8'h01, 8'h2C, 8'h2D, 8'hB4,
        8'h07, 8'hC0, 8'hA2, 8'h02, 8'h84, 8'hC1, 8'hC5, 8'hC2,
        8'h0A, 8'h00, 8'hC3, 8'h8A, 8'h2A, 8'hC4, 8'h8A, 8'hEE,
        8'hC5, 8'h0E, 8'h3A, 8'h05, 8'h36, 8'hC8, 8'h21, 8'h29
    };
    // one bit per entry, set for parameters
    localparam logic [TABLE_LEN-1:0] DATA_MASK =
        40'b0111_0111_0111_1110_1011_1010_1101_1011_0101_0100;

    logic                SYSTEM_CLK;
    logic                rst_n;
    logic [15:0]         pixel_color;
    logic                cs;
    logic                mosi;
    logic                dc;
    logic                lcd_clk;
    logic                lcd_reset;

    logic [15:0]         lfsr;
    lcd_cmd_pkg::pixel_t burst_color;
    string               test_name;
    int                  errors = 0;
    int                  checks = 0;
    int                  tests = 0;
    int                  failed_tests = 0;
    int                  errors_at_start = 0;
    int                  cycles = 0;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (8)
    ) clk_gen (
        .clk   (SYSTEM_CLK),
        .rst_n (rst_n)
    );

    st7735_ctrl #(
        .DELAY_CYCLES (DELAY_CYCLES),
        .WIDTH        (WIDTH),
        .HEIGHT       (HEIGHT)
    ) dut (
        .SYSTEM_CLK  (SYSTEM_CLK),
        .rst_n       (rst_n),
        .pixel_color (pixel_color),
        .cs          (cs),
        .mosi        (mosi),
        .dc          (dc),
        .lcd_clk     (lcd_clk),
        .lcd_reset   (lcd_reset)
    );

    always @(posedge SYSTEM_CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles in %s", cycles, test_name);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drive_new_color();
        lcd_cmd_pkg::pixel_t c;
        c = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_step(lfsr);
            c = {c[14:0], lfsr[0]};
        end
        pixel_color = c;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("%s: passed", test_name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic check_byte(input string what, input lcd_cmd_pkg::byte_t exp,
                              input lcd_cmd_pkg::byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s, %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_pixel(input string what, input lcd_cmd_pkg::pixel_t exp,
                               input lcd_cmd_pkg::pixel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s, %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s, %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input lcd_ctrl_pkg::bit_cnt_t exp,
                               input lcd_ctrl_pkg::bit_cnt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s, %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    // one cs-low burst, bits taken where lcd_clk has just risen
    task automatic collect_word(output lcd_ctrl_pkg::word_t word, output logic word_dc,
                                output lcd_ctrl_pkg::bit_cnt_t nbits);
        logic prev_clk;
        word = '0;
        word_dc = 1'b0;
        nbits = '0;
        @(negedge SYSTEM_CLK);
        while (cs !== 1'b0) begin
            @(negedge SYSTEM_CLK);
        end
        burst_color = pixel_color;
        prev_clk = lcd_clk;
        while (cs === 1'b0) begin
            @(negedge SYSTEM_CLK);
            if (lcd_clk === 1'b1 && prev_clk === 1'b0) begin
                word = {word[14:0], mosi};
                word_dc = dc;
                nbits = nbits + 1'b1;
            end
            prev_clk = lcd_clk;
        end
        drive_new_color();
    endtask

    task automatic expect_byte(input lcd_cmd_pkg::byte_t exp_byte, input logic exp_dc,
                               input int idx);
        lcd_ctrl_pkg::word_t    w;
        logic                   wdc;
        lcd_ctrl_pkg::bit_cnt_t n;
        collect_word(w, wdc, n);
        check_count($sformatf("word %0d length", idx), 5'd8, n);
        check_byte($sformatf("word %0d value", idx), exp_byte, w[7:0]);
        check_bit($sformatf("word %0d dc", idx), exp_dc, wdc);
    endtask

    task automatic check_window();
        lcd_cmd_pkg::byte_t exp_bytes [11];
        logic [10:0]        exp_dc;
        exp_bytes = '{8'h2A, 8'h00, 8'h00, 8'h00, 8'(WIDTH - 1),
                      8'h2B, 8'h00, 8'h00, 8'h00, 8'(HEIGHT - 1), 8'h2C};
        // first word in the top bit
        exp_dc = 11'b01111_01111_0;
        for (int i = 0; i < 11; i++) begin
            expect_byte(exp_bytes[i], exp_dc[10 - i], i);
        end
    endtask

    task automatic check_frame_pixels();
        lcd_ctrl_pkg::word_t    w;
        logic                   wdc;
        lcd_ctrl_pkg::bit_cnt_t n;
        for (int i = 0; i < WIDTH * HEIGHT; i++) begin
            collect_word(w, wdc, n);
            check_count($sformatf("pixel %0d length", i), 5'd16, n);
            check_bit($sformatf("pixel %0d dc", i), 1'b1, wdc);
            check_pixel($sformatf("pixel %0d value", i), burst_color, w);
        end
    endtask

    task automatic test_reset();
        int n;
        begin_test("reset");
        repeat (3) @(negedge SYSTEM_CLK);
        check_bit("cs in reset", 1'b1, cs);
        check_bit("lcd_clk in reset", 1'b1, lcd_clk);
        check_bit("mosi in reset", 1'b0, mosi);
        check_bit("dc in reset", 1'b0, dc);
        check_bit("lcd_reset in reset", 1'b0, lcd_reset);
        wait (rst_n === 1'b1);
        n = 0;
        while (lcd_reset !== 1'b1 && n < DELAY_CYCLES + 2) begin
            @(negedge SYSTEM_CLK);
            n++;
            check_bit($sformatf("cs at cycle %0d", n), 1'b1, cs);
            check_bit($sformatf("lcd_clk at cycle %0d", n), 1'b1, lcd_clk);
        end
        if (lcd_reset !== 1'b1) begin
            errors++;
            $display("%s: lcd_reset still low %0d cycles after reset release", test_name, n);
        end else if (n < DELAY_CYCLES) begin
            errors++;
            $display("%s: lcd_reset high only %0d cycles after reset release", test_name, n);
        end
        end_test();
    endtask

    task automatic test_wake();
        begin_test("wake-up");
        expect_byte(8'h11, 1'b0, 0);
        end_test();
    endtask

    task automatic test_config();
        begin_test("configuration");
        for (int i = 0; i < TABLE_LEN; i++) begin
            expect_byte(TABLE_BYTES[8 * (TABLE_LEN - 1 - i) +: 8],
                        DATA_MASK[TABLE_LEN - 1 - i], i);
        end
        end_test();
    endtask

    task automatic test_window();
        begin_test("window");
        check_window();
        end_test();
    endtask

    task automatic test_pixels();
        begin_test("pixels");
        check_frame_pixels();
        end_test();
    endtask

    task automatic test_second_frame();
        begin_test("second frame");
        check_window();
        check_frame_pixels();
        end_test();
    endtask

    initial begin
        lfsr = 16'd7764;
        pixel_color = '0;
        drive_new_color();
        test_reset();
        test_wake();
        test_config();
        test_window();
        test_pixels();
        test_second_frame();
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests, failed_tests, checks, errors, dut.pin_props.failures);
        if (errors == 0 && dut.pin_props.failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- st7735_ctrl_props.sv
`timescale 1ns/1ps

module st7735_ctrl_props (
    input logic SYSTEM_CLK,
    input logic rst_n,
    input logic cs,
    input logic dc,
    input logic lcd_clk,
    input logic lcd_reset
);

    int failures = 0;

    // serial clock idles high between words
    clk_idle_high: assert property (@(posedge SYSTEM_CLK) disable iff (!rst_n)
        cs |-> lcd_clk)
    else begin
        $error("lcd_clk low while cs is high");
        failures++;
    end

    // dc is fixed for the whole burst
    dc_steady: assert property (@(posedge SYSTEM_CLK) disable iff (!rst_n)
        (!cs && !$past(cs)) |-> $stable(dc))
    else begin
        $error("dc changed inside a cs-low burst");
        failures++;
    end

    reset_levels: assert property (@(posedge SYSTEM_CLK)
        !rst_n |=> (cs && !lcd_reset))
    else begin
        $error("cs low or lcd_reset high after a reset cycle");
        failures++;
    end

endmodule

bind st7735_ctrl st7735_ctrl_props pin_props (
    .SYSTEM_CLK (SYSTEM_CLK),
    .rst_n      (rst_n),
    .cs         (cs),
    .dc         (dc),
    .lcd_clk    (lcd_clk),
    .lcd_reset  (lcd_reset)
);

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // release lands on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- st7735_ctrl.sv
`timescale 1ns/1ps

module st7735_ctrl #(
    parameter int DELAY_CYCLES = 1_200_000,
    parameter int WIDTH        = 160,
    parameter int HEIGHT       = 120
) (
    input  logic        SYSTEM_CLK,
    input  logic        rst_n,
    input  logic [15:0] pixel_color,
    output logic        cs,
    output logic        mosi,
    output logic        dc,
    output logic        lcd_clk,
    output logic        lcd_reset
);

    logic                   delay_start;
    logic                   delay_done;
    lcd_cmd_pkg::rom_addr_t rom_addr;
    lcd_cmd_pkg::byte_t     rom_byte;
    logic                   rom_is_data;
    logic                   rom_last;

    spi_word_if word_bus ();

    spi_shifter u_shifter (
        .SYSTEM_CLK (SYSTEM_CLK),
        .rst_n      (rst_n),
        .bus        (word_bus.shifter),
        .cs         (cs),
        .mosi       (mosi),
        .dc         (dc),
        .lcd_clk    (lcd_clk)
    );

    delay_timer #(
        .DELAY_CYCLES (DELAY_CYCLES)
    ) u_delay (
        .SYSTEM_CLK  (SYSTEM_CLK),
        .rst_n       (rst_n),
        .delay_start (delay_start),
        .delay_done  (delay_done)
    );

    init_rom u_rom (
        .rom_addr    (rom_addr),
        .rom_byte    (rom_byte),
        .rom_is_data (rom_is_data),
        .rom_last    (rom_last)
    );

    lcd_sequencer #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) u_seq (
        .SYSTEM_CLK  (SYSTEM_CLK),
        .rst_n       (rst_n),
        .bus         (word_bus.seq),
        .delay_start (delay_start),
        .delay_done  (delay_done),
        .rom_addr    (rom_addr),
        .rom_byte    (rom_byte),
        .rom_is_data (rom_is_data),
        .rom_last    (rom_last),
        .pixel_color (pixel_color),
        .lcd_reset   (lcd_reset)
    );

endmodule

//--- lcd_sequencer.sv
`timescale 1ns/1ps

module lcd_sequencer #(
    parameter int WIDTH  = 160,
    parameter int HEIGHT = 120
) (
    input  logic                   SYSTEM_CLK,
    input  logic                   rst_n,
    spi_word_if.seq                bus,
    output logic                   delay_start,
    input  logic                   delay_done,
    output lcd_cmd_pkg::rom_addr_t rom_addr,
    input  lcd_cmd_pkg::byte_t     rom_byte,
    input  logic                   rom_is_data,
    input  logic                   rom_last,
    input  lcd_cmd_pkg::pixel_t    pixel_color,
    output logic                   lcd_reset
);

    lcd_ctrl_pkg::seq_state_t state;
    logic                     in_flight;
    logic [2:0]               win_idx;
    lcd_ctrl_pkg::pixel_cnt_t pixel_cnt;
    logic [15:0]              win_end;
    lcd_cmd_pkg::byte_t       tx_byte;
    logic                     tx_is_data;
    logic                     sending;
    logic                     launch;

    // byte for the current position
    always_comb begin
        tx_byte    = 8'h00;
        tx_is_data = lcd_cmd_pkg::DC_DATA;
        sending    = 1'b1;
        if (state == lcd_ctrl_pkg::raset) begin
            win_end = 16'(HEIGHT - 1);
        end else begin
            win_end = 16'(WIDTH - 1);
        end
        case (state)
            lcd_ctrl_pkg::wake_cmd: begin
                tx_byte    = lcd_cmd_pkg::CMD_SLPOUT;
                tx_is_data = lcd_cmd_pkg::DC_CMD;
            end
            lcd_ctrl_pkg::config_table: begin
                tx_byte    = rom_byte;
                tx_is_data = rom_is_data;
            end
            lcd_ctrl_pkg::caset, lcd_ctrl_pkg::raset: begin
                // start 0x0000, end at the last column or row
                case (win_idx)
                    3'd0: begin
                        tx_is_data = lcd_cmd_pkg::DC_CMD;
                        if (state == lcd_ctrl_pkg::caset) begin
                            tx_byte = lcd_cmd_pkg::CMD_CASET;
                        end else begin
                            tx_byte = lcd_cmd_pkg::CMD_RASET;
                        end
                    end
                    3'd3:    tx_byte = win_end[15:8];
                    3'd4:    tx_byte = win_end[7:0];
                    default: tx_byte = 8'h00;
                endcase
            end
            lcd_ctrl_pkg::ramwr: begin
                tx_byte    = lcd_cmd_pkg::CMD_RAMWR;
                tx_is_data = lcd_cmd_pkg::DC_CMD;
            end
            lcd_ctrl_pkg::pixels: begin
                tx_is_data = lcd_cmd_pkg::DC_DATA;
            end
            default: begin
                sending = 1'b0;
            end
        endcase
    end

    // one word at a time, next start two cycles after done at the earliest
    assign launch = sending && !in_flight && !bus.busy;

    always_ff @(posedge SYSTEM_CLK) begin
        if (launch) begin
            if (state == lcd_ctrl_pkg::pixels) begin
                bus.word <= pixel_color;
            end else begin
                bus.word <= {tx_byte, 8'h00};
            end
        end
    end

    always_ff @(posedge SYSTEM_CLK) begin
        if (!rst_n) begin
            state       <= lcd_ctrl_pkg::reset_hold;
            in_flight   <= 1'b0;
            win_idx     <= '0;
            pixel_cnt   <= '0;
            rom_addr    <= '0;
            lcd_reset   <= 1'b0;
            // hold delay runs from the first cycle out of reset
            delay_start <= 1'b1;
            bus.start   <= 1'b0;
            bus.is_data <= 1'b0;
            bus.wide    <= 1'b0;
        end else begin
            delay_start <= 1'b0;
            bus.start   <= 1'b0;
            if (launch) begin
                bus.start   <= 1'b1;
                bus.is_data <= tx_is_data;
                bus.wide    <= (state == lcd_ctrl_pkg::pixels);
                in_flight   <= 1'b1;
            end
            if (bus.done) begin
                in_flight <= 1'b0;
            end
            case (state)
                lcd_ctrl_pkg::reset_hold: begin
                    if (delay_done) begin
                        lcd_reset   <= 1'b1;
                        delay_start <= 1'b1;
                        state       <= lcd_ctrl_pkg::reset_wait;
                    end
                end
                lcd_ctrl_pkg::reset_wait: begin
                    if (delay_done) begin
                        state <= lcd_ctrl_pkg::wake_cmd;
                    end
                end
                lcd_ctrl_pkg::wake_cmd: begin
                    if (bus.done) begin
                        delay_start <= 1'b1;
                        state       <= lcd_ctrl_pkg::wake_wait;
                    end
                end
                lcd_ctrl_pkg::wake_wait: begin
                    if (delay_done) begin
                        rom_addr <= '0;
                        state    <= lcd_ctrl_pkg::config_table;
                    end
                end
                lcd_ctrl_pkg::config_table: begin
                    if (bus.done) begin
                        if (rom_last) begin
                            win_idx <= '0;
                            state   <= lcd_ctrl_pkg::caset;
                        end else begin
                            rom_addr <= rom_addr + 1'b1;
                        end
                    end
                end
                lcd_ctrl_pkg::caset, lcd_ctrl_pkg::raset: begin
                    if (bus.done) begin
                        if (win_idx == 3'd4) begin
                            win_idx <= '0;
                            if (state == lcd_ctrl_pkg::caset) begin
                                state <= lcd_ctrl_pkg::raset;
                            end else begin
                                state <= lcd_ctrl_pkg::ramwr;
                            end
                        end else begin
                            win_idx <= win_idx + 1'b1;
                        end
                    end
                end
                lcd_ctrl_pkg::ramwr: begin
                    if (bus.done) begin
                        pixel_cnt <= '0;
                        state     <= lcd_ctrl_pkg::pixels;
                    end
                end
                lcd_ctrl_pkg::pixels: begin
                    if (bus.done) begin
                        // frame complete, back to the window commands
                        if (pixel_cnt == lcd_ctrl_pkg::pixel_cnt_t'(WIDTH * HEIGHT - 1)) begin
                            win_idx <= '0;
                            state   <= lcd_ctrl_pkg::caset;
                        end else begin
                            pixel_cnt <= pixel_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= lcd_ctrl_pkg::reset_hold;
                end
            endcase
        end
    end

endmodule

//--- init_rom.sv
`timescale 1ns/1ps

module init_rom (
    input  lcd_cmd_pkg::rom_addr_t rom_addr,
    output lcd_cmd_pkg::byte_t     rom_byte,
    output logic                   rom_is_data,
    output logic                   rom_last
);

    // dc flag in the top bit, byte below
    logic [8:0] entry;

    always_comb begin
        case (rom_addr)
            // frame rate control
            6'd0:    entry = {lcd_cmd_pkg::DC_CMD,  8'hB1};
            6'd1:    entry = {lcd_cmd_pkg::DC_DATA, 8'h01};
            6'd2:    entry = {lcd_cmd_pkg::DC_DATA, 8'h2C};
            6'd3:    entry = {lcd_cmd_pkg::DC_DATA, 8'h2D};
            6'd4:    entry = {lcd_cmd_pkg::DC_CMD,  8'hB2};
            6'd5:    entry = {lcd_cmd_pkg::DC_DATA, 8'h01};
            6'd6:    entry = {lcd_cmd_pkg::DC_DATA, 8'h2C};
            6'd7:    entry = {lcd_cmd_pkg::DC_DATA, 8'h2D};
            6'd8:    entry = {lcd_cmd_pkg::DC_CMD,  8'hB3};
            6'd9:    entry = {lcd_cmd_pkg::DC_DATA, 8'h01};
            6'd10:   entry = {lcd_cmd_pkg::DC_DATA, 8'h2C};
            6'd11:   entry = {lcd_cmd_pkg::DC_DATA, 8'h2D};
            6'd12:   entry = {lcd_cmd_pkg::DC_DATA, 8'h01};
            6'd13:   entry = {lcd_cmd_pkg::DC_DATA, 8'h2C};
            6'd14:   entry = {lcd_cmd_pkg::DC_DATA, 8'h2D};
            // inversion control
            6'd15:   entry = {lcd_cmd_pkg::DC_CMD,  8'hB4};
            6'd16:   entry = {lcd_cmd_pkg::DC_DATA, 8'h07};
            // power control
            6'd17:   entry = {lcd_cmd_pkg::DC_CMD,  8'hC0};
            6'd18:   entry = {lcd_cmd_pkg::DC_DATA, 8'hA2};
            6'd19:   entry = {lcd_cmd_pkg::DC_DATA, 8'h02};
            6'd20:   entry = {lcd_cmd_pkg::DC_DATA, 8'h84};
            6'd21:   entry = {lcd_cmd_pkg::DC_CMD,  8'hC1};
            6'd22:   entry = {lcd_cmd_pkg::DC_DATA, 8'hC5};
            6'd23:   entry = {lcd_cmd_pkg::DC_CMD,  8'hC2};
            6'd24:   entry = {lcd_cmd_pkg::DC_DATA, 8'h0A};
            6'd25:   entry = {lcd_cmd_pkg::DC_DATA, 8'h00};
            6'd26:   entry = {lcd_cmd_pkg::DC_CMD,  8'hC3};
            6'd27:   entry = {lcd_cmd_pkg::DC_DATA, 8'h8A};
            6'd28:   entry = {lcd_cmd_pkg::DC_DATA, 8'h2A};
            6'd29:   entry = {lcd_cmd_pkg::DC_CMD,  8'hC4};
            6'd30:   entry = {lcd_cmd_pkg::DC_DATA, 8'h8A};
            6'd31:   entry = {lcd_cmd_pkg::DC_DATA, 8'hEE};
            6'd32:   entry = {lcd_cmd_pkg::DC_CMD,  8'hC5};
            6'd33:   entry = {lcd_cmd_pkg::DC_DATA, 8'h0E};
            // rgb565, row/column order, inversion on, display on
            6'd34:   entry = {lcd_cmd_pkg::DC_CMD,  8'h3A};
            6'd35:   entry = {lcd_cmd_pkg::DC_DATA, 8'h05};
            6'd36:   entry = {lcd_cmd_pkg::DC_CMD,  8'h36};
            6'd37:   entry = {lcd_cmd_pkg::DC_DATA, 8'hC8};
            6'd38:   entry = {lcd_cmd_pkg::DC_CMD,  8'h21};
            6'd39:   entry = {lcd_cmd_pkg::DC_CMD,  8'h29};
            default: entry = {lcd_cmd_pkg::DC_CMD,  8'h00};
        endcase
    end

    assign rom_is_data = entry[8];
    assign rom_byte    = entry[7:0];
    assign rom_last    = (rom_addr == lcd_cmd_pkg::rom_addr_t'(lcd_cmd_pkg::INIT_LEN - 1));

endmodule

//--- delay_timer.sv
`timescale 1ns/1ps

module delay_timer #(
    parameter int DELAY_CYCLES = 1_200_000
) (
    input  logic SYSTEM_CLK,
    input  logic rst_n,
    input  logic delay_start,
    output logic delay_done
);

    lcd_ctrl_pkg::delay_cnt_t count;

    // zero means idle; done lands DELAY_CYCLES after the start pulse
    always_ff @(posedge SYSTEM_CLK) begin
        if (!rst_n) begin
            count      <= '0;
            delay_done <= 1'b0;
        end else begin
            delay_done <= 1'b0;
            if (delay_start) begin
                count <= lcd_ctrl_pkg::delay_cnt_t'(DELAY_CYCLES - 1);
            end else if (count != '0) begin
                count      <= count - 1'b1;
                delay_done <= (count == lcd_ctrl_pkg::delay_cnt_t'(1));
            end
        end
    end

endmodule

//--- spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter (
    input  logic        SYSTEM_CLK,
    input  logic        rst_n,
    spi_word_if.shifter bus,
    output logic        cs,
    output logic        mosi,
    output logic        dc,
    output logic        lcd_clk
);

    lcd_ctrl_pkg::word_t    shift_reg;
    lcd_ctrl_pkg::bit_cnt_t bits_left;

    // msb goes out with the start, the rest one per falling lcd_clk
    always_ff @(posedge SYSTEM_CLK) begin
        if (bus.start && !bus.busy) begin
            shift_reg <= {bus.word[14:0], 1'b0};
        end else if (bus.busy && lcd_clk) begin
            shift_reg <= {shift_reg[14:0], 1'b0};
        end
    end

    always_ff @(posedge SYSTEM_CLK) begin
        if (!rst_n) begin
            cs        <= 1'b1;
            lcd_clk   <= 1'b1;
            mosi      <= 1'b0;
            dc        <= 1'b0;
            bits_left <= '0;
            bus.busy  <= 1'b0;
            bus.done  <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (!bus.busy) begin
                if (bus.start) begin
                    // cs and the first falling edge together
                    cs       <= 1'b0;
                    lcd_clk  <= 1'b0;
                    mosi     <= bus.word[15];
                    dc       <= bus.is_data;
                    bus.busy <= 1'b1;
                    if (bus.wide) begin
                        bits_left <= lcd_ctrl_pkg::bit_cnt_t'(lcd_ctrl_pkg::PIXEL_BITS);
                    end else begin
                        bits_left <= lcd_ctrl_pkg::bit_cnt_t'(lcd_ctrl_pkg::BYTE_BITS);
                    end
                end
            end else if (!lcd_clk) begin
                // rising edge, panel samples mosi here
                lcd_clk   <= 1'b1;
                bits_left <= bits_left - 1'b1;
                if (bits_left == lcd_ctrl_pkg::bit_cnt_t'(1)) begin
                    cs       <= 1'b1;
                    bus.busy <= 1'b0;
                    bus.done <= 1'b1;
                end
            end else begin
                lcd_clk <= 1'b0;
                mosi    <= shift_reg[15];
            end
        end
    end

endmodule

//--- spi_word_if.sv
`timescale 1ns/1ps

interface spi_word_if;

    logic                start;
    lcd_ctrl_pkg::word_t word;
    logic                is_data;
    logic                wide;
    logic                busy;
    logic                done;

    modport seq (
        output start,
        output word,
        output is_data,
        output wide,
        input  busy,
        input  done
    );

    modport shifter (
        input  start,
        input  word,
        input  is_data,
        input  wide,
        output busy,
        output done
    );

endinterface

//--- lcd_ctrl_pkg.sv
package lcd_ctrl_pkg;

    // sequencer states
    typedef enum logic [3:0] {
        reset_hold,
        reset_wait,
        wake_cmd,
        wake_wait,
        config_table,
        caset,
        raset,
        ramwr,
        pixels
    } seq_state_t;

    // shift word, a byte sits in the upper half
    typedef logic [15:0] word_t;

    localparam int BYTE_BITS  = 8;
    localparam int PIXEL_BITS = 16;

    // wide enough for 16 bits still to send
    typedef logic [4:0]  bit_cnt_t;

    // pixels per frame
    typedef logic [19:0] pixel_cnt_t;

    // delay periods in system cycles
    typedef logic [23:0] delay_cnt_t;

endpackage

//--- lcd_cmd_pkg.sv
package lcd_cmd_pkg;

    // one byte on the serial line, one rgb565 pixel
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] pixel_t;

    // index into the configuration table
    typedef logic [5:0]  rom_addr_t;

    // dc level on the panel: low for a command, high for a parameter or pixel
    localparam logic DC_CMD  = 1'b0;
    localparam logic DC_DATA = 1'b1;

    // commands sent outside the table
    localparam byte_t CMD_SLPOUT = 8'h11;
    localparam byte_t CMD_CASET  = 8'h2A;
    localparam byte_t CMD_RASET  = 8'h2B;
    localparam byte_t CMD_RAMWR  = 8'h2C;

    // entries in the configuration table, commands and parameters together
    localparam int INIT_LEN = 40;

endpackage
